/* Bender.yml */
package:
  name: rv_int_core

sources:
  - riscv_isa_pkg.sv
  - core_pkg.sv
  - rv_immediate.sv
  - rv_decoder.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_writeback.sv
  - rv_int_core.sv
  - target: simulation
    files:
      - tb_rv_int_core.sv

/* core_pkg.sv */
package core_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        JAL,
        JALR
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        ILLEGAL_INSTR,
        INSTR_ADDR_MISALIGNED
    } xcpt_cause_e;

    typedef struct packed {
        riscv_isa_pkg::xlen_t       pc;
        riscv_isa_pkg::instr_word_t inst;
    } fetch_instr_t;

    typedef struct packed {
        riscv_isa_pkg::xlen_t     pc;
        riscv_isa_pkg::reg_addr_t rs1;
        riscv_isa_pkg::reg_addr_t rs2;
        riscv_isa_pkg::reg_addr_t rd;
        riscv_isa_pkg::xlen_t     imm;
        alu_op_e                  op;
        logic                     use_imm;
        logic                     use_pc;
        logic                     op_32;      // word op, result sign-extended from bit 31
        logic                     regfile_we;
        xcpt_cause_e              xcpt_cause;
        riscv_isa_pkg::xlen_t     xcpt_origin;
    } decoded_instr_t;

    typedef struct packed {
        riscv_isa_pkg::xlen_t     pc;
        riscv_isa_pkg::reg_addr_t rd;
        logic                     regfile_we;
        riscv_isa_pkg::xlen_t     wdata;
        riscv_isa_pkg::xlen_t     next_pc;
        xcpt_cause_e              xcpt_cause;
        riscv_isa_pkg::xlen_t     xcpt_origin;
    } exec_result_t;

    // external retire record, same layout as exec_result_t
    typedef struct packed {
        riscv_isa_pkg::xlen_t     pc;
        riscv_isa_pkg::reg_addr_t rd;
        logic                     regfile_we;
        riscv_isa_pkg::xlen_t     wdata;
        riscv_isa_pkg::xlen_t     next_pc;
        xcpt_cause_e              xcpt_cause;
        riscv_isa_pkg::xlen_t     xcpt_origin;
    } retire_t;

    typedef struct packed {
        logic                     we;
        riscv_isa_pkg::reg_addr_t addr;
        riscv_isa_pkg::xlen_t     data;
    } rf_write_t;

endpackage

/* riscv_isa_pkg.sv */
package riscv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;       // data and pc
    typedef logic [ILEN-1:0]       instr_word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;

    // major opcodes, kept subset only
    localparam opcode_t OP_LUI     = 7'b0110111;
    localparam opcode_t OP_AUIPC   = 7'b0010111;
    localparam opcode_t OP_JAL     = 7'b1101111;
    localparam opcode_t OP_JALR    = 7'b1100111;
    localparam opcode_t OP_ALU_I   = 7'b0010011;
    localparam opcode_t OP_ALU     = 7'b0110011;
    localparam opcode_t OP_ALU_I_W = 7'b0011011;
    localparam opcode_t OP_ALU_W   = 7'b0111011;

    // funct3, shared by reg and imm forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_NORMAL  = 7'b0000000;
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;   // also srai

endpackage

/* rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
    input  core_pkg::fetch_instr_t   fetch_i,
    input  logic                     valid_i,
    output core_pkg::decoded_instr_t decoded_o
);

    import riscv_isa_pkg::*;
    import core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm;
    xlen_t      jal_target;
    logic       illegal;
    logic       misaligned;

    rv_immediate u_rv_immediate (
        .instr_i (fetch_i.inst),
        .imm_o   (imm)
    );

    assign opcode     = fetch_i.inst[6:0];
    assign funct3     = fetch_i.inst[14:12];
    assign funct7     = fetch_i.inst[31:25];
    assign jal_target = fetch_i.pc + imm;

    always_comb begin
        illegal    = 1'b0;
        misaligned = 1'b0;

        decoded_o.pc         = fetch_i.pc;
        decoded_o.rs1        = fetch_i.inst[19:15];
        decoded_o.rs2        = fetch_i.inst[24:20];
        decoded_o.rd         = fetch_i.inst[11:7];
        decoded_o.imm        = imm;
        decoded_o.op         = ADD;
        decoded_o.use_imm    = 1'b0;
        decoded_o.use_pc     = 1'b0;
        decoded_o.op_32      = 1'b0;
        decoded_o.regfile_we = 1'b0;

        if (valid_i) begin
            decoded_o.regfile_we = 1'b1;    // every kept class writes rd
            decoded_o.use_imm    = (opcode != OP_ALU) && (opcode != OP_ALU_W);
            case (opcode)
                OP_LUI: begin
                    decoded_o.rs1 = '0;     // 0 | imm
                    decoded_o.op  = OR;
                end
                OP_AUIPC: begin
                    decoded_o.use_pc = 1'b1;
                end
                OP_JAL: begin
                    decoded_o.use_pc = 1'b1;
                    decoded_o.op     = JAL;
                    misaligned       = |jal_target[1:0];
                end
                OP_JALR: begin
                    decoded_o.op = JALR;
                    illegal      = (funct3 != 3'b000);
                end
                OP_ALU_I: begin
                    case (funct3)
                        F3_ADD_SUB: decoded_o.op = ADD;
                        F3_SLT:     decoded_o.op = SLT;
                        F3_SLTU:    decoded_o.op = SLTU;
                        F3_XOR:     decoded_o.op = XOR;
                        F3_OR:      decoded_o.op = OR;
                        F3_AND:     decoded_o.op = AND;
                        F3_SLL: begin
                            decoded_o.op = SLL;
                            illegal      = (funct7[6:1] != F7_NORMAL[6:1]);  // bit 25 is shamt[5]
                        end
                        default: begin  // srli / srai
                            if (funct7[6:1] == F7_SUB_SRA[6:1]) begin
                                decoded_o.op = SRA;
                            end else begin
                                decoded_o.op = SRL;
                                illegal      = (funct7[6:1] != F7_NORMAL[6:1]);
                            end
                        end
                    endcase
                end
                OP_ALU: begin
                    case ({funct7, funct3})
                        {F7_NORMAL, F3_ADD_SUB}:  decoded_o.op = ADD;
                        {F7_SUB_SRA, F3_ADD_SUB}: decoded_o.op = SUB;
                        {F7_NORMAL, F3_SLL}:      decoded_o.op = SLL;
                        {F7_NORMAL, F3_SLT}:      decoded_o.op = SLT;
                        {F7_NORMAL, F3_SLTU}:     decoded_o.op = SLTU;
                        {F7_NORMAL, F3_XOR}:      decoded_o.op = XOR;
                        {F7_NORMAL, F3_SRL_SRA}:  decoded_o.op = SRL;
                        {F7_SUB_SRA, F3_SRL_SRA}: decoded_o.op = SRA;
                        {F7_NORMAL, F3_OR}:       decoded_o.op = OR;
                        {F7_NORMAL, F3_AND}:      decoded_o.op = AND;
                        default:                  illegal = 1'b1;
                    endcase
                end
                OP_ALU_I_W: begin
                    decoded_o.op_32 = 1'b1;
                    case ({funct7, funct3}) inside
                        {7'b???????, F3_ADD_SUB}: decoded_o.op = ADD;
                        {F7_NORMAL, F3_SLL}:      decoded_o.op = SLL;
                        {F7_NORMAL, F3_SRL_SRA}:  decoded_o.op = SRL;
                        {F7_SUB_SRA, F3_SRL_SRA}: decoded_o.op = SRA;
                        default:                  illegal = 1'b1;
                    endcase
                end
                OP_ALU_W: begin
                    decoded_o.op_32 = 1'b1;
                    case ({funct7, funct3})
                        {F7_NORMAL, F3_ADD_SUB}:  decoded_o.op = ADD;
                        {F7_SUB_SRA, F3_ADD_SUB}: decoded_o.op = SUB;
                        {F7_NORMAL, F3_SLL}:      decoded_o.op = SLL;
                        {F7_NORMAL, F3_SRL_SRA}:  decoded_o.op = SRL;
                        {F7_SUB_SRA, F3_SRL_SRA}: decoded_o.op = SRA;
                        default:                  illegal = 1'b1;
                    endcase
                end
                default: illegal = 1'b1;
            endcase
        end

        // misaligned jal wins, origin is the bad target
        decoded_o.xcpt_cause  = NONE;
        decoded_o.xcpt_origin = '0;
        if (misaligned) begin
            decoded_o.xcpt_cause  = INSTR_ADDR_MISALIGNED;
            decoded_o.xcpt_origin = jal_target;
            decoded_o.regfile_we  = 1'b0;
        end else if (illegal) begin
            decoded_o.xcpt_cause = ILLEGAL_INSTR;
            decoded_o.regfile_we = 1'b0;
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
    input  core_pkg::decoded_instr_t decoded_i,
    input  riscv_isa_pkg::xlen_t     rs1_data_i,
    input  riscv_isa_pkg::xlen_t     rs2_data_i,
    output core_pkg::exec_result_t   result_o
);

    import riscv_isa_pkg::*;
    import core_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      sum;
    xlen_t      shift_src;
    xlen_t      alu_res;
    xlen_t      pc_plus4;
    xlen_t      jump_target;
    logic [5:0] shamt;
    logic       is_jump;
    logic       xcpt;

    assign op_a     = decoded_i.use_pc ? decoded_i.pc : rs1_data_i;
    assign op_b     = decoded_i.use_imm ? decoded_i.imm : rs2_data_i;
    assign sum      = op_a + op_b;       // also the jump target
    assign pc_plus4 = decoded_i.pc + 64'd4;
    assign shamt    = decoded_i.op_32 ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign is_jump  = (decoded_i.op == JAL) || (decoded_i.op == JALR);
    assign xcpt     = (decoded_i.xcpt_cause != NONE);

    assign jump_target = (decoded_i.op == JALR) ? {sum[XLEN-1:1], 1'b0} : sum;

    // word shifts work on the low half, zero or sign filled
    always_comb begin
        shift_src = op_a;
        if (decoded_i.op_32) begin
            if (decoded_i.op == SRA) begin
                shift_src = {{32{op_a[31]}}, op_a[31:0]};
            end else begin
                shift_src = {32'b0, op_a[31:0]};
            end
        end
    end

    always_comb begin
        case (decoded_i.op)
            ADD:       alu_res = sum;
            SUB:       alu_res = op_a - op_b;
            SLL:       alu_res = op_a << shamt;
            SLT:       alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:      alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:       alu_res = op_a ^ op_b;
            SRL:       alu_res = shift_src >> shamt;
            SRA:       alu_res = $signed(shift_src) >>> shamt;
            OR:        alu_res = op_a | op_b;
            AND:       alu_res = op_a & op_b;
            JAL, JALR: alu_res = pc_plus4;   // link value
            default:   alu_res = sum;
        endcase
        if (decoded_i.op_32) begin
            alu_res = {{32{alu_res[31]}}, alu_res[31:0]};
        end
    end

    always_comb begin
        result_o.pc          = decoded_i.pc;
        result_o.rd          = decoded_i.rd;
        result_o.regfile_we  = decoded_i.regfile_we & ~xcpt;
        result_o.wdata       = xcpt ? '0 : alu_res;
        result_o.next_pc     = (is_jump && !xcpt) ? jump_target : pc_plus4;
        result_o.xcpt_cause  = decoded_i.xcpt_cause;
        result_o.xcpt_origin = decoded_i.xcpt_origin;
    end

endmodule

/* rv_immediate.sv */
`timescale 1ns/100ps

module rv_immediate (
    input  riscv_isa_pkg::instr_word_t instr_i,
    output riscv_isa_pkg::xlen_t       imm_o
);

    import riscv_isa_pkg::*;

    opcode_t opcode;

    assign opcode = instr_i[6:0];

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: begin
                // upper 20 bits, low 12 zero
                imm_o = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
            end
            OP_JAL: begin
                imm_o = {{44{instr_i[31]}},
                         instr_i[19:12],
                         instr_i[20],
                         instr_i[30:21],
                         1'b0};            // J-type, always even
            end
            default: begin
                // I-type covers jalr and all alu imm forms
                imm_o = {{52{instr_i[31]}}, instr_i[31:20]};
            end
        endcase
    end

endmodule

/* rv_int_core.f */
riscv_isa_pkg.sv
core_pkg.sv
rv_immediate.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_writeback.sv
rv_int_core.sv
tb_rv_int_core.sv

/* rv_int_core.sv */
`timescale 1ns/100ps

module rv_int_core (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  instr_valid_i,
    input  core_pkg::fetch_instr_t instr_i,
    output logic                  instr_ready_o,
    output logic                  retire_valid_o,
    output core_pkg::retire_t     retire_o,
    input  logic                  retire_ready_i
);

    import riscv_isa_pkg::*;
    import core_pkg::*;

    logic           stall;
    fetch_instr_t   s1_q;
    logic           s1_valid_q;
    decoded_instr_t decoded;
    decoded_instr_t s2_q;
    logic           s2_valid_q;
    xlen_t          rs1_data;
    xlen_t          rs2_data;
    exec_result_t   exec_res;
    rf_write_t      rf_wr;

    // whole pipe freezes while the retire record is refused
    assign stall         = retire_valid_o & ~retire_ready_i;
    assign instr_ready_o = ~stall;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (!stall) begin
            s1_valid_q <= instr_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            s1_q <= instr_i;
            s2_q <= decoded;
        end
    end

    rv_decoder u_rv_decoder (
        .fetch_i   (s1_q),
        .valid_i   (s1_valid_q),
        .decoded_o (decoded)
    );

    rv_regfile u_rv_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (s2_q.rs1),
        .rs2_i      (s2_q.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (rf_wr)
    );

    rv_execute u_rv_execute (
        .decoded_i  (s2_q),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (exec_res)
    );

    rv_writeback u_rv_writeback (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .result_i       (exec_res),
        .valid_i        (s2_valid_q),
        .stall_i        (stall),
        .rf_wr_o        (rf_wr),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

/* rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  riscv_isa_pkg::reg_addr_t rs1_i,
    input  riscv_isa_pkg::reg_addr_t rs2_i,
    output riscv_isa_pkg::xlen_t     rs1_data_o,
    output riscv_isa_pkg::xlen_t     rs2_data_o,
    input  core_pkg::rf_write_t      wr_i
);

    import riscv_isa_pkg::*;

    xlen_t regs [1:NUM_REGS-1];   // x0 has no storage

    // x0 reads zero, a write in flight is forwarded
    function automatic xlen_t read_port(reg_addr_t addr);
        xlen_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_i.we && (wr_i.addr == addr)) begin
            data = wr_i.data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

endmodule

/* rv_writeback.sv */
`timescale 1ns/100ps

module rv_writeback (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  core_pkg::exec_result_t result_i,
    input  logic                   valid_i,
    input  logic                   stall_i,
    output core_pkg::rf_write_t    rf_wr_o,
    output logic                   retire_valid_o,
    output core_pkg::retire_t      retire_o
);

    import core_pkg::*;

    exec_result_t s3_q;
    logic         s3_valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s3_valid_q <= 1'b0;
        end else if (!stall_i) begin
            s3_valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            s3_q <= result_i;
        end
    end

    assign retire_valid_o = s3_valid_q;
    assign retire_o       = retire_t'(s3_q);

    // write only on the edge the record leaves, never to x0
    assign rf_wr_o.we   = s3_valid_q & ~stall_i & s3_q.regfile_we & (s3_q.rd != '0);
    assign rf_wr_o.addr = s3_q.rd;
    assign rf_wr_o.data = s3_q.wdata;

endmodule

/* tb_rv_int_core.sv */
`timescale 1ns/100ps

module tb_rv_int_core;

    import riscv_isa_pkg::*;
    import core_pkg::*;

    localparam int LAT_COUNT  = 24;     // back-to-back, ready held high
    localparam int RAND_COUNT = 400;
    localparam int TOTAL      = LAT_COUNT + RAND_COUNT;
    localparam int WAIT_LIMIT = 200;

    logic         clk_i;
    logic         rst_n_i;
    logic         instr_valid_i;
    fetch_instr_t instr_i;
    logic         instr_ready_o;
    logic         retire_valid_o;
    retire_t      retire_o;
    logic         retire_ready_i;

    xlen_t        model_regs [NUM_REGS];
    fetch_instr_t exp_q [$];
    int           accept_edge_q [$];
    bit           timed_q [$];
    int           retired_cnt;
    logic         bp_en;
    logic         lat_phase;

    rv_int_core u_rv_int_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic compare_record(input string tag, input retire_t got, input retire_t exp);
        check_value({tag, ".pc"}, got.pc, exp.pc);
        check_value({tag, ".rd"}, got.rd, exp.rd);
        check_value({tag, ".regfile_we"}, got.regfile_we, exp.regfile_we);
        check_value({tag, ".wdata"}, got.wdata, exp.wdata);
        check_value({tag, ".next_pc"}, got.next_pc, exp.next_pc);
        check_value({tag, ".xcpt_cause"}, got.xcpt_cause, exp.xcpt_cause);
        check_value({tag, ".xcpt_origin"}, got.xcpt_origin, exp.xcpt_origin);
    endtask

    function automatic xlen_t alu64(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
        xlen_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[5:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011:  r = (a < b) ? 64'd1 : 64'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // word forms only use add/sub and the shifts
    function automatic xlen_t alu32(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'b001:  r = a[31:0] << b[4:0];
            3'b101: begin
                if (alt) begin
                    r = $signed(a[31:0]) >>> b[4:0];
                end else begin
                    r = a[31:0] >> b[4:0];
                end
            end
            default: r = '0;
        endcase
        return {{32{r[31]}}, r};
    endfunction

    // expected retire record from the RV64I rules and the model registers
    function automatic retire_t ref_retire(input fetch_instr_t f);
        retire_t     r;
        instr_word_t w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm_i;
        xlen_t       imm_u;
        xlen_t       imm_j;
        xlen_t       res;
        xlen_t       target;
        logic        bad;
        logic        alt;
        w     = f.inst;
        f3    = w[14:12];
        f7    = w[31:25];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_u = {{32{w[31]}}, w[31:12], 12'h000};
        imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        bad   = 1'b0;
        alt   = (f3 == F3_SRL_SRA) && f7[5];   // sra flag on the imm forms
        res   = '0;

        r.pc          = f.pc;
        r.rd          = w[11:7];
        r.regfile_we  = 1'b1;
        r.next_pc     = f.pc + 64'd4;
        r.xcpt_cause  = NONE;
        r.xcpt_origin = '0;

        case (w[6:0])
            OP_LUI:   res = imm_u;
            OP_AUIPC: res = f.pc + imm_u;
            OP_JAL: begin
                target = f.pc + imm_j;
                res    = f.pc + 64'd4;
                if (target[1:0] != 2'b00) begin
                    r.xcpt_cause  = INSTR_ADDR_MISALIGNED;
                    r.xcpt_origin = target;
                end else begin
                    r.next_pc = target;
                end
            end
            OP_JALR: begin
                target    = a + imm_i;
                target[0] = 1'b0;
                res       = f.pc + 64'd4;
                bad       = (f3 != 3'b000);
                if (!bad) begin
                    r.next_pc = target;
                end
            end
            OP_ALU_I: begin
                if (f3 == F3_SLL) begin
                    bad = (f7[6:1] != 6'b000000);
                end else if (f3 == F3_SRL_SRA) begin
                    bad = (f7[6:1] != 6'b000000) && (f7[6:1] != 6'b010000);
                end
                res = alu64(f3, alt, a, imm_i);
            end
            OP_ALU: begin
                alt = f7[5];
                bad = (f7 != 7'b0000000) &&
                      !((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
                res = alu64(f3, alt, a, b);
            end
            OP_ALU_I_W: begin
                case (f3)
                    3'b000:  bad = 1'b0;
                    3'b001:  bad = (f7 != 7'b0000000);
                    3'b101:  bad = (f7 != 7'b0000000) && (f7 != 7'b0100000);
                    default: bad = 1'b1;
                endcase
                res = alu32(f3, alt, a, imm_i);
            end
            OP_ALU_W: begin
                alt = f7[5];
                case (f3)
                    3'b000, 3'b101: bad = (f7 != 7'b0000000) && (f7 != 7'b0100000);
                    3'b001:         bad = (f7 != 7'b0000000);
                    default:        bad = 1'b1;
                endcase
                res = alu32(f3, alt, a, b);
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            r.xcpt_cause  = ILLEGAL_INSTR;
            r.xcpt_origin = '0;
        end
        if (r.xcpt_cause != NONE) begin
            r.regfile_we = 1'b0;
            r.wdata      = '0;
        end else begin
            r.wdata = res;
        end
        return r;
    endfunction

    // small register range so that dependencies are frequent
    function automatic reg_addr_t rand_reg();
        if ($urandom_range(0, 9) == 0) begin
            return reg_addr_t'($urandom);
        end
        return reg_addr_t'($urandom_range(0, 7));
    endfunction

    function automatic logic [6:0] pick_funct7();
        int r;
        r = $urandom_range(0, 9);
        if (r < 5) begin
            return F7_NORMAL;
        end else if (r < 8) begin
            return F7_SUB_SRA;
        end
        return 7'($urandom);
    endfunction

    function automatic logic [2:0] pick_funct3_w();
        int r;
        r = $urandom_range(0, 7);
        if (r < 3) begin
            return F3_ADD_SUB;
        end else if (r == 3) begin
            return F3_SLL;
        end else if (r < 6) begin
            return F3_SRL_SRA;
        end
        return 3'($urandom);
    endfunction

    function automatic xlen_t rand_pc();
        xlen_t pc;
        pc = {$urandom, $urandom};
        if ($urandom_range(0, 7) != 0) begin
            pc[1:0] = 2'b00;
        end
        return pc;
    endfunction

    function automatic instr_word_t gen_instr();
        instr_word_t w;
        int          kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        opcode_t     opc;
        kind  = $urandom_range(0, 99);
        f3    = 3'($urandom);
        f7    = pick_funct7();
        imm12 = 12'($urandom);
        if (kind < 8) begin
            w = {20'($urandom), rand_reg(), OP_LUI};
        end else if (kind < 14) begin
            w = {20'($urandom), rand_reg(), OP_AUIPC};
        end else if (kind < 22) begin
            w = {20'($urandom), rand_reg(), OP_JAL};
        end else if (kind < 30) begin
            if ($urandom_range(0, 4) != 0) begin
                f3 = 3'b000;
            end
            w = {imm12, rand_reg(), f3, rand_reg(), OP_JALR};
        end else if (kind < 55) begin
            if ((f3 == F3_SLL) || (f3 == F3_SRL_SRA)) begin
                imm12[11:6] = f7[6:1];     // shamt[5] stays random
            end
            w = {imm12, rand_reg(), f3, rand_reg(), OP_ALU_I};
        end else if (kind < 75) begin
            w = {f7, rand_reg(), rand_reg(), f3, rand_reg(), OP_ALU};
        end else if (kind < 85) begin
            f3 = pick_funct3_w();
            if (f3 != F3_ADD_SUB) begin
                imm12 = {f7, 5'($urandom)};
            end
            w = {imm12, rand_reg(), f3, rand_reg(), OP_ALU_I_W};
        end else if (kind < 95) begin
            w = {f7, rand_reg(), rand_reg(), pick_funct3_w(), rand_reg(), OP_ALU_W};
        end else begin
            opc = 7'($urandom);
            if (opc inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                            OP_ALU_I, OP_ALU, OP_ALU_I_W, OP_ALU_W}) begin
                opc = 7'b0000011;   // load, not in the core
            end
            w = {25'($urandom), opc};
        end
        return w;
    endfunction

    task automatic send_instr(input fetch_instr_t f);
        int waited;
        waited = 0;
        instr_valid_i <= 1'b1;
        instr_i       <= f;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("instruction was not accepted within the timeout");
            end
        end while (instr_ready_o !== 1'b1);
    endtask

    task automatic wait_retired(input int count);
        int waited;
        waited = 0;
        while (retired_cnt < count) begin
            @(posedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT * 4) begin
                abort_run("pipeline did not drain within the timeout");
            end
        end
    endtask

    initial begin : ready_proc
        int low_len;
        retire_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            if ((bp_en === 1'b1) && ($urandom_range(0, 3) == 0)) begin
                low_len = $urandom_range(1, 5);
                retire_ready_i <= 1'b0;
                repeat (low_len) @(posedge clk_i);
                retire_ready_i <= 1'b1;
            end
        end
    end

    // sampled at the rising edge, both handshakes use pre-edge values
    initial begin : compare_proc
        fetch_instr_t acc;
        retire_t      exp_rec;
        retire_t      held_rec;
        logic         holding;
        int           cyc;
        int           idle;
        int           acc_edge;
        bit           timed;
        retired_cnt  = 0;
        holding      = 1'b0;
        cyc          = 0;
        idle         = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        forever begin
            @(posedge clk_i);
            cyc++;
            if ((rst_n_i === 1'b1) && (instr_valid_i === 1'b1) && (instr_ready_o === 1'b1)) begin
                exp_q.push_back(instr_i);
                accept_edge_q.push_back(cyc);
                timed_q.push_back(lat_phase);
            end
            if (exp_q.size() == 0) begin
                idle = 0;
            end else begin
                idle++;
            end
            if (holding) begin
                check_value("retire_valid_o while stalled", retire_valid_o, 1'b1);
                compare_record("stalled retire_o", retire_o, held_rec);
            end
            holding = 1'b0;
            if (retire_valid_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("retire record seen with no instruction outstanding");
                end
                if (retire_ready_i === 1'b1) begin
                    acc      = exp_q.pop_front();
                    acc_edge = accept_edge_q.pop_front();
                    timed    = timed_q.pop_front();
                    exp_rec  = ref_retire(acc);
                    compare_record("retire_o", retire_o, exp_rec);
                    if (timed) begin
                        check_value("retire latency", 64'(cyc - acc_edge), 64'd3);
                    end
                    if (exp_rec.regfile_we && (exp_rec.rd != '0)) begin
                        model_regs[exp_rec.rd] = exp_rec.wdata;
                    end
                    retired_cnt++;
                    idle = 0;
                end else begin
                    holding  = 1'b1;
                    held_rec = retire_o;
                end
            end
            if (idle > WAIT_LIMIT) begin
                abort_run("no instruction retired within the timeout");
            end
        end
    end

    initial begin : driver_proc
        int           gap;
        fetch_instr_t f;
        void'($urandom(32'h25cc));
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        bp_en         = 1'b0;
        lat_phase     = 1'b1;
        repeat (10) @(posedge clk_i);
        check_value("retire_valid_o after reset", retire_valid_o, 1'b0);
        check_value("instr_ready_o after reset", instr_ready_o, 1'b1);
        rst_n_i <= 1'b1;

        for (int i = 0; i < LAT_COUNT; i++) begin
            f.pc   = rand_pc();
            f.inst = gen_instr();
            send_instr(f);
        end
        instr_valid_i <= 1'b0;
        wait_retired(LAT_COUNT);

        // random gaps and back-pressure from here on
        lat_phase <= 1'b0;
        bp_en     <= 1'b1;
        for (int i = 0; i < RAND_COUNT; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                instr_valid_i <= 1'b0;
                gap = $urandom_range(1, 4);
                repeat (gap) @(posedge clk_i);
            end
            f.pc   = rand_pc();
            f.inst = gen_instr();
            send_instr(f);
        end
        instr_valid_i <= 1'b0;
        wait_retired(TOTAL);
        repeat (4) @(posedge clk_i);   // longer than the three-stage pipe

        if (retire_valid_o === 1'b0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("retire port still valid after the last instruction retired");
        end
    end

endmodule
